// File: common/nnTypesPkg.sv
package nnTypesPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// widths and sizes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int actW = 8;
	localparam int weightW = 8;
	localparam int accW = 20; // 15 products of u8 x s8 plus a bias cannot overflow this
	localparam int classW = 2;

	localparam int nInputs = 15;
	localparam int nHidden = 4;
	localparam int nClasses = 3;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// scalar types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [actW-1:0] actT; // inputs, hidden values and scores
	typedef logic signed [weightW-1:0] weightT;
	typedef logic signed [accW-1:0] accT;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bundles
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		actT [nInputs-1:0] acts;
	} sampleT;

	typedef struct packed {
		logic [classW-1:0] classId;
		actT score; // winning output-layer activation
	} resultT;

endpackage

// File: common/nnWeightsPkg.sv
package nnWeightsPkg;

	import nnTypesPkg::*;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// hidden layer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Rows run from neuron 3 down to neuron 0, and each row lists input 14 first
	localparam weightT [nHidden-1:0][nInputs-1:0] hiddenWeights = {
		{-8'sd38, -8'sd21, 8'sd66, -8'sd7, 8'sd14, 8'sd83, -8'sd31, 8'sd9,
			8'sd25, -8'sd44, 8'sd52, 8'sd17, 8'sd4, -8'sd60, 8'sd33}, // neuron 3
		{8'sd70, 8'sd29, -8'sd2, 8'sd46, -8'sd19, 8'sd54, 8'sd37, -8'sd88,
			8'sd11, 8'sd61, -8'sd25, -8'sd6, 8'sd72, 8'sd15, -8'sd40}, // neuron 2
		{8'sd8, -8'sd57, 8'sd31, -8'sd14, 8'sd90, -8'sd9, 8'sd22, 8'sd40,
			-8'sd71, 8'sd5, -8'sd18, 8'sd64, 8'sd27, -8'sd33, 8'sd12}, // neuron 1
		{-8'sd51, -8'sd4, -8'sd12, -8'sd30, -8'sd53, 8'sd78, -8'sd43, 8'sd68,
			8'sd43, 8'sd18, 8'sd116, 8'sd23, -8'sd51, 8'sd49, -8'sd9} // neuron 0
	};

	localparam weightT [nHidden-1:0] hiddenBias = {
		8'sd64,
		-8'sd12,
		8'sd20,
		-8'sd1
	};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output layer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// rows run from class 2 down to class 0, hidden input 3 first
	localparam weightT [nClasses-1:0][nHidden-1:0] outWeights = {
		{8'sd60, 8'sd30, -8'sd45, 8'sd90}, // class 2
		{-8'sd35, 8'sd55, 8'sd75, -8'sd20}, // class 1
		{8'sd85, -8'sd60, 8'sd40, 8'sd40} // class 0
	};

	localparam weightT [nClasses-1:0] outBias = {
		-8'sd10,
		8'sd5,
		8'sd0
	};

	// right shift after rectifying, keeps bits [13:6] of the sum
	localparam int actShift = 6;

endpackage

// File: neuron/neuronNode.sv
`timescale 1ns/1ps

module neuronNode
	import nnTypesPkg::*;
#(
	parameter int nIn = nInputs,
	parameter weightT [nIn-1:0] weights = '0,
	parameter weightT bias = '0,
	parameter int shift = 6
)
(
	input logic clk,
	input logic reset,
	input actT [nIn-1:0] acts,
	output actT act
);

	actT [nIn-1:0] actsQ; // stage 1
	accT sumNext;
	accT sumQ; // stage 2
	accT scaled;
	actT actNext;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 1 input register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk)
	begin
		if (reset)
			actsQ <= '0;
		else
			actsQ <= acts;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 2 weighted sum plus bias
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb
	begin
		sumNext = accT'(bias);
		for (int i = 0; i < nIn; i++)
		begin
			// activation is unsigned, so a zero is put in front before the signed multiply
			sumNext = sumNext + accT'(signed'({1'b0, actsQ[i]})) * accT'(weights[i]);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			sumQ <= '0;
		else
			sumQ <= sumNext;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 3 rectify, shift, saturate
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign scaled = sumQ >>> shift;

	always_comb
	begin
		if (sumQ[accW-1])
			actNext = '0; // negative sums rectify to zero
		else if (|scaled[accW-1:actW])
			actNext = '1; // anything past 255 clips
		else
			actNext = scaled[actW-1:0];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			act <= '0;
		else
			act <= actNext;
	end

	actZeroAfterReset: assert property (@(posedge clk) reset |=> act == '0)
		else $error("neuron output not cleared by reset");

endmodule

// File: neuron/neuronLayer.sv
`timescale 1ns/1ps

module neuronLayer
	import nnTypesPkg::*;
#(
	parameter int nIn = nInputs,
	parameter int nOut = nHidden,
	parameter weightT [nOut-1:0][nIn-1:0] weights = '0,
	parameter weightT [nOut-1:0] biases = '0,
	parameter int shift = 6
)
(
	input logic clk,
	input logic reset,
	input logic inStrobe,
	input actT [nIn-1:0] acts,
	output logic outStrobe,
	output actT [nOut-1:0] outActs
);

	localparam int nodeLatency = 3; // register stages inside neuronNode

	logic [nodeLatency-1:0] strobePipe;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// strobe delay line
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk)
	begin
		if (reset)
			strobePipe <= '0;
		else
			strobePipe <= {strobePipe[nodeLatency-2:0], inStrobe};
	end

	assign outStrobe = strobePipe[nodeLatency-1]; // lines up with the neuron outputs

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// neurons, all fed from the same vector
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	for (genvar n = 0; n < nOut; n++)
	begin : gNeuron
		neuronNode #(
			.nIn(nIn),
			.weights(weights[n]),
			.bias(biases[n]),
			.shift(shift)
		) node_i (
			.clk(clk),
			.reset(reset),
			.acts(acts),
			.act(outActs[n])
		);
	end

	// a held reset must keep the whole delay line flushed, even with inStrobe high
	noStrobeInReset: assert property (@(posedge clk) reset && $past(reset) |-> !outStrobe)
		else $error("layer strobe seen during reset");

endmodule

// File: hdl/classSelect.sv
`timescale 1ns/1ps

module classSelect
	import nnTypesPkg::*;
#(
	parameter int nIn = nClasses
)
(
	input logic clk,
	input logic reset,
	input logic scoreStrobe,
	input actT [nIn-1:0] scores,
	output logic outStrobe,
	output resultT result
);

	logic [classW-1:0] bestId;
	actT bestScore;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// arg-max
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb
	begin
		bestId = '0;
		bestScore = scores[0];
		for (int i = 1; i < nIn; i++)
		begin
			if (scores[i] > bestScore) // strict compare keeps the lowest index on a tie
			begin
				bestId = classW'(i);
				bestScore = scores[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outStrobe <= 1'b0;
			result <= '0;
		end
		else
		begin
			outStrobe <= scoreStrobe;
			if (scoreStrobe)
				result <= '{classId: bestId, score: bestScore}; // holds until the next sample
		end
	end

	classInRange: assert property (@(posedge clk) disable iff (reset)
		outStrobe |-> int'(result.classId) < nIn)
		else $error("class index %0d out of range", result.classId);

endmodule

// File: hdl/mlpClassifier.sv
`timescale 1ns/1ps

module mlpClassifier
	import nnTypesPkg::*;
	import nnWeightsPkg::*;
#(
	parameter weightT [nHidden-1:0][nInputs-1:0] hiddenW = hiddenWeights,
	parameter weightT [nHidden-1:0] hiddenB = hiddenBias,
	parameter weightT [nClasses-1:0][nHidden-1:0] outW = outWeights,
	parameter weightT [nClasses-1:0] outB = outBias,
	parameter int shift = actShift
)
(
	input logic clk,
	input logic reset,
	input logic inStrobe,
	input sampleT sample,
	output logic outStrobe,
	output resultT result
);

	logic hiddenStrobe;
	actT [nHidden-1:0] hiddenActs;
	logic scoreStrobe;
	actT [nClasses-1:0] scores;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// hidden layer takes 3 cycles
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	neuronLayer #(
		.nIn(nInputs),
		.nOut(nHidden),
		.weights(hiddenW),
		.biases(hiddenB),
		.shift(shift)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inStrobe(inStrobe),
		.acts(sample.acts),
		.outStrobe(hiddenStrobe),
		.outActs(hiddenActs)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output layer takes 3 cycles
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	neuronLayer #(
		.nIn(nHidden),
		.nOut(nClasses),
		.weights(outW),
		.biases(outB),
		.shift(shift)
	) outputLayer (
		.clk(clk),
		.reset(reset),
		.inStrobe(hiddenStrobe),
		.acts(hiddenActs),
		.outStrobe(scoreStrobe),
		.outActs(scores)
	);

	// class selector adds the last cycle
	classSelect #(
		.nIn(nClasses)
	) selector (
		.clk(clk),
		.reset(reset),
		.scoreStrobe(scoreStrobe),
		.scores(scores),
		.outStrobe(outStrobe),
		.result(result)
	);

endmodule

// File: dv/mlpRefModel.svh
`ifndef MLP_REF_MODEL_SVH
`define MLP_REF_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model of the classifier
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// negative sums give zero, the rest is shifted down and clipped at 255
function automatic int rectifyScale(input int sum);
	int scaled;
	if (sum < 0)
		return 0;
	scaled = sum >> actShift;
	if (scaled > 255)
		return 255;
	return scaled;
endfunction

function automatic int hiddenValue(input sampleT s, input int n);
	int sum;
	sum = int'($signed(hiddenBias[n]));
	for (int i = 0; i < nInputs; i++)
		sum += int'(s.acts[i]) * int'($signed(hiddenWeights[n][i])); // unsigned act, signed weight
	return rectifyScale(sum);
endfunction

function automatic int outputScore(input actT [nHidden-1:0] hidden, input int c);
	int sum;
	sum = int'($signed(outBias[c]));
	for (int h = 0; h < nHidden; h++)
		sum += int'(hidden[h]) * int'($signed(outWeights[c][h]));
	return rectifyScale(sum);
endfunction

function automatic resultT expectedResult(input sampleT s);
	actT [nHidden-1:0] hidden;
	actT [nClasses-1:0] scores;
	resultT r;
	for (int n = 0; n < nHidden; n++)
		hidden[n] = actT'(hiddenValue(s, n));
	for (int c = 0; c < nClasses; c++)
		scores[c] = actT'(outputScore(hidden, c));
	r.classId = '0;
	r.score = scores[0];
	for (int c = 1; c < nClasses; c++)
	begin
		if (scores[c] > r.score) // lowest index keeps a tie
		begin
			r.classId = 2'(c);
			r.score = scores[c];
		end
	end
	return r;
endfunction

`endif

// File: dv/mlpClassifierTb.sv
`timescale 1ns/1ps

module mlpClassifierTb
	import nnTypesPkg::*;
	import nnWeightsPkg::*;
();

	localparam int clkPeriod = 8;
	localparam int latency = 7; // input strobe to result strobe
	localparam int nRows = 8;
	localparam int nRandom = 40;
	localparam int nSamples = nRows + nRandom;
	localparam int watchdogNs = (nSamples + 20) * clkPeriod * 2;

	logic clk;
	logic reset;
	logic inStrobe;
	sampleT sample;
	logic outStrobe;
	resultT result;

	int cycleCount = 0;
	logic [31:0] rngState = 32'd80351;

	string rowName [nRows];
	sampleT rowSample [nRows];
	int rowGap [nRows]; // idle cycles after the row, zero means back to back
	resultT rowExpected [nRows];

	resultT expectQ [$];
	string nameQ [$];
	int cycleQ [$];

	`include "mlpRefModel.svh"

	mlpClassifier mlpClassifier_i (
		.clk(clk),
		.reset(reset),
		.inStrobe(inStrobe),
		.sample(sample),
		.outStrobe(outStrobe),
		.result(result)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	always @(posedge clk)
		cycleCount <= cycleCount + 1;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic failRun(input string why);
		$display("*** FAILED ***");
		$fatal(1, "%s", why);
	endtask

	task automatic check(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("error %s expected %0h actual %0h", testName, expected, actual);
			failRun({"wrong value in ", testName});
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic sampleT fill(input actT value);
		sampleT s;
		for (int i = 0; i < nInputs; i++)
			s.acts[i] = value;
		return s;
	endfunction

	function automatic sampleT spike(input int index, input actT value);
		sampleT s;
		s = '0;
		s.acts[index] = value;
		return s;
	endfunction

	task automatic addRow(input int idx, input string name, input sampleT s, input int gap,
		input logic [1:0] cls, input actT scoreValue);
		rowName[idx] = name;
		rowSample[idx] = s;
		rowGap[idx] = gap;
		rowExpected[idx].classId = cls;
		rowExpected[idx].score = scoreValue;
	endtask

	task automatic buildTable();
		addRow(0, "allZero", fill(8'd0), 2, 2'd0, 8'd1); // bias only, class 1 clamps at zero
		addRow(1, "allMax", fill(8'd255), 0, 2'd0, 8'd255); // everything clips, three-way tie
		addRow(2, "zeroTie", spike(13, 8'd1), 1, 2'd0, 8'd0); // all scores zero
		addRow(3, "spikeIn4", spike(4, 8'd255), 0, 2'd0, 8'd255); // classes 0 and 2 tie
		addRow(4, "spikeIn1", spike(1, 8'd255), 0, 2'd2, 8'd255);
		addRow(5, "spikeIn10", spike(10, 8'd255), 2, 2'd1, 8'd255);
		addRow(6, "midIn10", spike(10, 8'd64), 0, 2'd1, 8'd97); // no clipping on the winner
		addRow(7, "spikeIn0", spike(0, 8'd255), 1, 2'd0, 8'd205);
	endtask

	task automatic randomSample(output sampleT s, output int gap);
		for (int i = 0; i < nInputs; i++)
		begin
			rngState = xorshift(rngState);
			s.acts[i] = rngState[7:0] >> rngState[9:8]; // smaller ranges keep some scores unclipped
		end
		rngState = xorshift(rngState);
		gap = (rngState[1:0] == 2'd0) ? 1 : 0; // mostly back to back
	endtask

	task automatic sendSample(input string name, input sampleT s, input resultT expected,
		input int gap);
		@(negedge clk);
		inStrobe = 1'b1;
		sample = s;
		expectQ.push_back(expected);
		nameQ.push_back(name);
		cycleQ.push_back(cycleCount);
		for (int g = 0; g < gap; g++)
		begin
			@(negedge clk);
			inStrobe = 1'b0;
			sample = ~s; // must be ignored while inStrobe is low
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// monitor, watchdog and stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(negedge clk)
	begin : monitor
		string name;
		resultT expected;
		int startCycle;
		if (!reset && outStrobe !== 1'b0)
		begin
			if (outStrobe !== 1'b1)
				failRun("outStrobe is unknown after reset");
			else if (expectQ.size() == 0)
				failRun("outStrobe pulsed with no sample in flight");
			else
			begin
				name = nameQ.pop_front();
				expected = expectQ.pop_front();
				startCycle = cycleQ.pop_front();
				check({name, " latency"}, latency, cycleCount - startCycle);
				check(name, expected, result);
			end
		end
	end

	initial
	begin : watchdog
		#(watchdogNs);
		failRun("timeout, the run did not finish in time");
	end

	initial
	begin : stimulus
		sampleT s;
		int gap;
		reset = 1'b1;
		inStrobe = 1'b0;
		sample = '0;
		buildTable();
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		repeat (5) @(negedge clk); // idle, any outStrobe here is a failure

		for (int r = 0; r < nRows; r++)
		begin
			check({rowName[r], " model"}, rowExpected[r], expectedResult(rowSample[r]));
			sendSample(rowName[r], rowSample[r], rowExpected[r], rowGap[r]);
		end
		for (int n = 0; n < nRandom; n++)
		begin
			randomSample(s, gap);
			sendSample($sformatf("random%0d", n), s, expectedResult(s), gap);
		end
		@(negedge clk);
		inStrobe = 1'b0;
		sample = '0;
		repeat (latency + 4) @(negedge clk);

		if (expectQ.size() != 0)
			failRun("samples still waiting for a result at the end of the run");
		else
		begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

// File: sim.f
+incdir+dv
common/nnTypesPkg.sv
common/nnWeightsPkg.sv
neuron/neuronNode.sv
neuron/neuronLayer.sv
hdl/classSelect.sv
hdl/mlpClassifier.sv
dv/mlpClassifierTb.sv

// File: Makefile
TOP := mlpClassifierTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
